/* verilog/wb_defines.svh */
// width, depth and machine CSR address macros, included by the RTL and the bench
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// datapath widths
`define WORD_WD      64
`define PC_WD        64
`define INST_WD      32

// register file addressing
`define GPR_ADDR_WD  5
`define CSR_ADDR_WD  12

// data RAM word address, 256 words of WORD_WD bits
`define DRAM_AW      8

// machine CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`endif

/* verilog/wb_pkg.sv */
// stage payload structs and memory-op encodings shared by the back-end pipeline modules
`include "wb_defines.svh"

package wb_pkg;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  typedef struct packed {
    logic [`PC_WD-1:0]       pc;
    logic [`INST_WD-1:0]     inst;
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    // address for loads and stores
    logic [`WORD_WD-1:0]     alu_result;
    mem_op_e                 mem_op;
    mem_size_e               mem_size;
    logic                    load_unsigned;
    logic [`WORD_WD-1:0]     store_data;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_addr;
    logic [`WORD_WD-1:0]     csr_result;
  } ex_to_ms_t;

  typedef struct packed {
    logic [`PC_WD-1:0]       pc;
    logic [`INST_WD-1:0]     inst;
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`WORD_WD-1:0]     gpr_final_result;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_addr;
    logic [`WORD_WD-1:0]     csr_final_result;
  } ms_to_ws_t;

  typedef struct packed {
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] gpr_waddr;
    logic [`WORD_WD-1:0]     gpr_wdata;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_waddr;
    logic [`WORD_WD-1:0]     csr_wdata;
  } ws_to_rf_t;

endpackage

/* verilog/data_ram.sv */
// single-port data RAM, combinational read and byte-strobed write, used by the memory stage
`include "wb_defines.svh"

module data_ram (
  input  logic                  i_clk,
  input  logic [`DRAM_AW-1:0]   i_addr,
  input  logic                  i_wen,
  input  logic [`WORD_WD/8-1:0] i_wstrb,
  input  logic [`WORD_WD-1:0]   i_wdata,
  output logic [`WORD_WD-1:0]   o_rdata
);

  localparam int DEPTH = 1 << `DRAM_AW;
  localparam int NBYTES = `WORD_WD / 8;

  logic [`WORD_WD-1:0] mem [0:DEPTH-1];

  // only enabled byte lanes are updated
  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (i_wstrb[b]) begin
          mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // read is async so a load sees data in its own cycle
  assign o_rdata = mem[i_addr];

endmodule

/* verilog/mem_stage.sv */
// memory-access stage; registers the execute payload, drives the data RAM and aligns loads
`include "wb_defines.svh"

module mem_stage (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_ex_to_ms_valid,
  input  wb_pkg::ex_to_ms_t        i_ex_to_ms_bus,
  output logic                     o_ms_allowin,
  input  logic                     i_ws_allowin,
  output logic                     o_ms_to_ws_valid,
  output wb_pkg::ms_to_ws_t        o_ms_to_ws_bus,
  output logic [`DRAM_AW-1:0]      o_dram_addr,
  output logic                     o_dram_wen,
  output logic [`WORD_WD/8-1:0]    o_dram_wstrb,
  output logic [`WORD_WD-1:0]      o_dram_wdata,
  input  logic [`WORD_WD-1:0]      i_dram_rdata,
  output logic [`GPR_ADDR_WD-1:0]  o_ms_to_ds_gpr_rd,
  output logic [`CSR_ADDR_WD-1:0]  o_ms_to_ds_csr_rd
);
  import wb_pkg::*;

  logic                  ms_valid;
  logic                  ms_ready_go;
  ex_to_ms_t             ms_bus_r;
  logic [2:0]            byte_off;
  logic [5:0]            bit_off;
  logic [`WORD_WD/8-1:0] size_strb;
  logic [2:0]            align_mask;
  logic [`WORD_WD-1:0]   load_shifted;
  logic [`WORD_WD-1:0]   load_result;
  logic                  load_sign;

  assign ms_ready_go      = 1'b1;
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_ex_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ex_to_ms_valid && o_ms_allowin) begin
      ms_bus_r <= i_ex_to_ms_bus;
    end
  end

  assign byte_off = ms_bus_r.alu_result[2:0];
  assign bit_off  = {byte_off, 3'b000};

  always_comb begin
    size_strb  = 8'hff;
    align_mask = 3'b111;
    case (ms_bus_r.mem_size)
      SIZE_B: begin
        size_strb  = 8'h01;
        align_mask = 3'b000;
      end
      SIZE_H: begin
        size_strb  = 8'h03;
        align_mask = 3'b001;
      end
      SIZE_W: begin
        size_strb  = 8'h0f;
        align_mask = 3'b011;
      end
      default: begin
        size_strb  = 8'hff;
        align_mask = 3'b111;
      end
    endcase
  end

  // store path, data moved into its byte lanes
  assign o_dram_addr  = ms_bus_r.alu_result[`DRAM_AW+2:3];
  assign o_dram_wen   = ms_valid && (ms_bus_r.mem_op == MEM_STORE);
  assign o_dram_wstrb = size_strb << byte_off;
  assign o_dram_wdata = ms_bus_r.store_data << bit_off;

  // load path
  assign load_shifted = i_dram_rdata >> bit_off;

  always_comb begin
    load_sign   = 1'b0;
    load_result = load_shifted;
    case (ms_bus_r.mem_size)
      SIZE_B: begin
        load_sign   = load_shifted[7] && !ms_bus_r.load_unsigned;
        load_result = {{(`WORD_WD-8){load_sign}}, load_shifted[7:0]};
      end
      SIZE_H: begin
        load_sign   = load_shifted[15] && !ms_bus_r.load_unsigned;
        load_result = {{(`WORD_WD-16){load_sign}}, load_shifted[15:0]};
      end
      SIZE_W: begin
        load_sign   = load_shifted[31] && !ms_bus_r.load_unsigned;
        load_result = {{(`WORD_WD-32){load_sign}}, load_shifted[31:0]};
      end
      default: begin
        load_sign   = 1'b0;
        load_result = load_shifted;
      end
    endcase
  end

  always_comb begin
    o_ms_to_ws_bus.pc               = ms_bus_r.pc;
    o_ms_to_ws_bus.inst             = ms_bus_r.inst;
    o_ms_to_ws_bus.gpr_wen          = ms_bus_r.gpr_wen;
    o_ms_to_ws_bus.rd               = ms_bus_r.rd;
    o_ms_to_ws_bus.gpr_final_result = (ms_bus_r.mem_op == MEM_LOAD) ? load_result
                                                                    : ms_bus_r.alu_result;
    o_ms_to_ws_bus.csr_wen          = ms_bus_r.csr_wen;
    o_ms_to_ws_bus.csr_addr         = ms_bus_r.csr_addr;
    o_ms_to_ws_bus.csr_final_result = ms_bus_r.csr_result;
  end

  // destinations for decode's hazard check
  assign o_ms_to_ds_gpr_rd = (ms_valid && ms_bus_r.gpr_wen) ? ms_bus_r.rd : '0;
  assign o_ms_to_ds_csr_rd = (ms_valid && ms_bus_r.csr_wen) ? ms_bus_r.csr_addr : '0;

  // execute only issues naturally aligned accesses
  a_aligned_access: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (ms_valid && ms_bus_r.mem_op != MEM_NONE) |-> ((byte_off & align_mask) == 3'b000));

endmodule

/* verilog/wb_stage.sv */
// write-back stage; turns the memory payload into the register-file write bus and retire trace
`include "wb_defines.svh"

module wb_stage (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  output logic                     o_ws_allowin,
  input  logic                     i_ms_to_ws_valid,
  input  wb_pkg::ms_to_ws_t        i_ms_to_ws_bus,
  output wb_pkg::ws_to_rf_t        o_ws_to_rf_bus,
  output logic [`GPR_ADDR_WD-1:0]  o_ws_to_ds_gpr_rd,
  output logic [`CSR_ADDR_WD-1:0]  o_ws_to_ds_csr_rd,
  output logic                     o_retire_valid,
  output logic [`PC_WD-1:0]        o_retire_pc,
  output logic [`INST_WD-1:0]      o_retire_inst
);
  import wb_pkg::*;

  logic      ws_valid;
  logic      ws_ready_go;
  ms_to_ws_t ws_bus_r;

  assign ws_ready_go  = 1'b1;
  assign o_ws_allowin = !ws_valid || ws_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ws_valid <= 1'b0;
    end else if (o_ws_allowin) begin
      ws_valid <= i_ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_to_ws_valid && o_ws_allowin) begin
      ws_bus_r <= i_ms_to_ws_bus;
    end
  end

  // enables qualified by valid so a bubble never writes
  always_comb begin
    o_ws_to_rf_bus.gpr_wen   = ws_valid && ws_bus_r.gpr_wen;
    o_ws_to_rf_bus.gpr_waddr = ws_bus_r.rd;
    o_ws_to_rf_bus.gpr_wdata = ws_bus_r.gpr_final_result;
    o_ws_to_rf_bus.csr_wen   = ws_valid && ws_bus_r.csr_wen;
    o_ws_to_rf_bus.csr_waddr = ws_bus_r.csr_addr;
    o_ws_to_rf_bus.csr_wdata = ws_bus_r.csr_final_result;
  end

  assign o_ws_to_ds_gpr_rd = (ws_valid && ws_bus_r.gpr_wen) ? ws_bus_r.rd : '0;
  assign o_ws_to_ds_csr_rd = (ws_valid && ws_bus_r.csr_wen) ? ws_bus_r.csr_addr : '0;

  // retire trace
  assign o_retire_valid = ws_valid;
  assign o_retire_pc    = ws_bus_r.pc;
  assign o_retire_inst  = ws_bus_r.inst;

  // any register write must trace back to a handoff from mem on the previous edge
  a_wen_needs_item: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_ws_to_rf_bus.gpr_wen || o_ws_to_rf_bus.csr_wen)
      |-> $past(i_ms_to_ws_valid && o_ws_allowin));

endmodule

/* verilog/gpr_file.sv */
// integer register file, x0 hardwired to zero, written from the write-back bus
`include "wb_defines.svh"

module gpr_file (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  wb_pkg::ws_to_rf_t       i_ws_to_rf_bus,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr,
  output logic [`WORD_WD-1:0]     o_rdata
);

  localparam int NREGS = 1 << `GPR_ADDR_WD;

  // no storage behind x0
  logic [`WORD_WD-1:0] gpr_q [1:NREGS-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (i_ws_to_rf_bus.gpr_wen && (i_ws_to_rf_bus.gpr_waddr != '0)) begin
      gpr_q[i_ws_to_rf_bus.gpr_waddr] <= i_ws_to_rf_bus.gpr_wdata;
    end
  end

  assign o_rdata = (i_raddr == '0) ? '0 : gpr_q[i_raddr];

endmodule

/* verilog/csr_file.sv */
// machine CSRs (mstatus, mtvec, mepc, mcause) written from write-back, read by decode
`include "wb_defines.svh"

module csr_file (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  wb_pkg::ws_to_rf_t       i_ws_to_rf_bus,
  input  logic [`CSR_ADDR_WD-1:0] i_raddr,
  output logic [`WORD_WD-1:0]     o_rdata
);

  logic [`WORD_WD-1:0] mstatus_q;
  logic [`WORD_WD-1:0] mtvec_q;
  logic [`WORD_WD-1:0] mepc_q;
  logic [`WORD_WD-1:0] mcause_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (i_ws_to_rf_bus.csr_wen) begin
      case (i_ws_to_rf_bus.csr_waddr)
        `CSR_MSTATUS: mstatus_q <= i_ws_to_rf_bus.csr_wdata;
        `CSR_MTVEC:   mtvec_q   <= i_ws_to_rf_bus.csr_wdata;
        `CSR_MEPC:    mepc_q    <= i_ws_to_rf_bus.csr_wdata;
        `CSR_MCAUSE:  mcause_q  <= i_ws_to_rf_bus.csr_wdata;
        // unimplemented address, write dropped
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      `CSR_MSTATUS: o_rdata = mstatus_q;
      `CSR_MTVEC:   o_rdata = mtvec_q;
      `CSR_MEPC:    o_rdata = mepc_q;
      `CSR_MCAUSE:  o_rdata = mcause_q;
      default:      o_rdata = '0;
    endcase
  end

endmodule

/* verilog/wb_top.sv */
// back-end top: memory stage, write-back stage, data RAM and the GPR/CSR files
`include "wb_defines.svh"

module wb_top (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_ex_to_ms_valid,
  input  wb_pkg::ex_to_ms_t        i_ex_to_ms_bus,
  output logic                     o_ms_allowin,
  input  logic [`GPR_ADDR_WD-1:0]  i_gpr_raddr,
  output logic [`WORD_WD-1:0]      o_gpr_rdata,
  input  logic [`CSR_ADDR_WD-1:0]  i_csr_raddr,
  output logic [`WORD_WD-1:0]      o_csr_rdata,
  output logic [`GPR_ADDR_WD-1:0]  o_ms_to_ds_gpr_rd,
  output logic [`CSR_ADDR_WD-1:0]  o_ms_to_ds_csr_rd,
  output logic [`GPR_ADDR_WD-1:0]  o_ws_to_ds_gpr_rd,
  output logic [`CSR_ADDR_WD-1:0]  o_ws_to_ds_csr_rd,
  output logic                     o_retire_valid,
  output logic [`PC_WD-1:0]        o_retire_pc,
  output logic [`INST_WD-1:0]      o_retire_inst
);
  import wb_pkg::*;

  logic                  ws_allowin;
  logic                  ms_to_ws_valid;
  ms_to_ws_t             ms_to_ws_bus;
  ws_to_rf_t             ws_to_rf_bus;
  logic [`DRAM_AW-1:0]   dram_addr;
  logic                  dram_wen;
  logic [`WORD_WD/8-1:0] dram_wstrb;
  logic [`WORD_WD-1:0]   dram_wdata;
  logic [`WORD_WD-1:0]   dram_rdata;

  mem_stage u_mem_stage (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_ex_to_ms_valid  (i_ex_to_ms_valid),
    .i_ex_to_ms_bus    (i_ex_to_ms_bus),
    .o_ms_allowin      (o_ms_allowin),
    .i_ws_allowin      (ws_allowin),
    .o_ms_to_ws_valid  (ms_to_ws_valid),
    .o_ms_to_ws_bus    (ms_to_ws_bus),
    .o_dram_addr       (dram_addr),
    .o_dram_wen        (dram_wen),
    .o_dram_wstrb      (dram_wstrb),
    .o_dram_wdata      (dram_wdata),
    .i_dram_rdata      (dram_rdata),
    .o_ms_to_ds_gpr_rd (o_ms_to_ds_gpr_rd),
    .o_ms_to_ds_csr_rd (o_ms_to_ds_csr_rd)
  );

  data_ram u_data_ram (
    .i_clk   (i_clk),
    .i_addr  (dram_addr),
    .i_wen   (dram_wen),
    .i_wstrb (dram_wstrb),
    .i_wdata (dram_wdata),
    .o_rdata (dram_rdata)
  );

  wb_stage u_wb_stage (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .o_ws_allowin      (ws_allowin),
    .i_ms_to_ws_valid  (ms_to_ws_valid),
    .i_ms_to_ws_bus    (ms_to_ws_bus),
    .o_ws_to_rf_bus    (ws_to_rf_bus),
    .o_ws_to_ds_gpr_rd (o_ws_to_ds_gpr_rd),
    .o_ws_to_ds_csr_rd (o_ws_to_ds_csr_rd),
    .o_retire_valid    (o_retire_valid),
    .o_retire_pc       (o_retire_pc),
    .o_retire_inst     (o_retire_inst)
  );

  gpr_file u_gpr_file (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ws_to_rf_bus (ws_to_rf_bus),
    .i_raddr        (i_gpr_raddr),
    .o_rdata        (o_gpr_rdata)
  );

  csr_file u_csr_file (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ws_to_rf_bus (ws_to_rf_bus),
    .i_raddr        (i_csr_raddr),
    .o_rdata        (o_csr_rdata)
  );

endmodule

/* bench/tb_wb_top.sv */
// bench for wb_top; random execute payloads against a reference model, checked by assertions
`include "wb_defines.svh"

module tb_wb_top;
  import wb_pkg::*;

  localparam int WAIT_LIMIT = 200;
  localparam int RAM_WORDS  = 16;

  logic                    i_clk;
  logic                    i_arst_n;
  logic                    i_ex_to_ms_valid;
  ex_to_ms_t               i_ex_to_ms_bus;
  logic                    o_ms_allowin;
  logic [`GPR_ADDR_WD-1:0] i_gpr_raddr;
  logic [`WORD_WD-1:0]     o_gpr_rdata;
  logic [`CSR_ADDR_WD-1:0] i_csr_raddr;
  logic [`WORD_WD-1:0]     o_csr_rdata;
  logic [`GPR_ADDR_WD-1:0] o_ms_to_ds_gpr_rd;
  logic [`CSR_ADDR_WD-1:0] o_ms_to_ds_csr_rd;
  logic [`GPR_ADDR_WD-1:0] o_ws_to_ds_gpr_rd;
  logic [`CSR_ADDR_WD-1:0] o_ws_to_ds_csr_rd;
  logic                    o_retire_valid;
  logic [`PC_WD-1:0]       o_retire_pc;
  logic [`INST_WD-1:0]     o_retire_inst;

  // reference model state
  logic [`WORD_WD-1:0]        m_gpr [0:31];
  logic [`WORD_WD-1:0]        m_csr [0:3];
  logic [`WORD_WD-1:0]        m_ram [0:(1 << `DRAM_AW)-1];
  logic                       m_ms_valid;
  logic                       m_ws_valid;
  ex_to_ms_t                  m_ms;
  ms_to_ws_t                  m_ws;
  logic [`PC_WD+`INST_WD-1:0] retire_q [$];
  logic [`PC_WD-1:0]          exp_ws_pc;
  logic [`INST_WD-1:0]        exp_ws_inst;
  logic [`WORD_WD-1:0]        exp_gpr_rdata;
  logic [`WORD_WD-1:0]        exp_csr_rdata;
  logic [`PC_WD-1:0]          next_pc;
  logic [`GPR_ADDR_WD-1:0]    exp_ms_gpr_rd;
  logic [`CSR_ADDR_WD-1:0]    exp_ms_csr_rd;
  logic [`GPR_ADDR_WD-1:0]    exp_ws_gpr_rd;
  logic [`CSR_ADDR_WD-1:0]    exp_ws_csr_rd;

  wb_top DUT (.*);

  assign exp_ms_gpr_rd = (m_ms_valid && m_ms.gpr_wen) ? m_ms.rd : '0;
  assign exp_ms_csr_rd = (m_ms_valid && m_ms.csr_wen) ? m_ms.csr_addr : '0;
  assign exp_ws_gpr_rd = (m_ws_valid && m_ws.gpr_wen) ? m_ws.rd : '0;
  assign exp_ws_csr_rd = (m_ws_valid && m_ws.csr_wen) ? m_ws.csr_addr : '0;

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("[ERROR] t=%0t %s expected %h got %h", $time, sig, exp_v, act_v);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at t=%0t while waiting for %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  a_allowin: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_ms_allowin)
    else report_mismatch("o_ms_allowin", 64'd1, 64'($sampled(o_ms_allowin)));
  a_retire_valid: assert property (@(posedge i_clk) o_retire_valid == m_ws_valid)
    else report_mismatch("o_retire_valid", 64'($sampled(m_ws_valid)),
                         64'($sampled(o_retire_valid)));
  a_retire_pc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    m_ws_valid |-> (o_retire_pc == exp_ws_pc))
    else report_mismatch("o_retire_pc", $sampled(exp_ws_pc), $sampled(o_retire_pc));
  a_retire_inst: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    m_ws_valid |-> (o_retire_inst == exp_ws_inst))
    else report_mismatch("o_retire_inst", 64'($sampled(exp_ws_inst)),
                         64'($sampled(o_retire_inst)));
  a_ms_gpr_rd: assert property (@(posedge i_clk) o_ms_to_ds_gpr_rd == exp_ms_gpr_rd)
    else report_mismatch("o_ms_to_ds_gpr_rd", 64'($sampled(exp_ms_gpr_rd)),
                         64'($sampled(o_ms_to_ds_gpr_rd)));
  a_ms_csr_rd: assert property (@(posedge i_clk) o_ms_to_ds_csr_rd == exp_ms_csr_rd)
    else report_mismatch("o_ms_to_ds_csr_rd", 64'($sampled(exp_ms_csr_rd)),
                         64'($sampled(o_ms_to_ds_csr_rd)));
  a_ws_gpr_rd: assert property (@(posedge i_clk) o_ws_to_ds_gpr_rd == exp_ws_gpr_rd)
    else report_mismatch("o_ws_to_ds_gpr_rd", 64'($sampled(exp_ws_gpr_rd)),
                         64'($sampled(o_ws_to_ds_gpr_rd)));
  a_ws_csr_rd: assert property (@(posedge i_clk) o_ws_to_ds_csr_rd == exp_ws_csr_rd)
    else report_mismatch("o_ws_to_ds_csr_rd", 64'($sampled(exp_ws_csr_rd)),
                         64'($sampled(o_ws_to_ds_csr_rd)));
  a_gpr_rdata: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_gpr_rdata == exp_gpr_rdata)
    else report_mismatch("o_gpr_rdata", $sampled(exp_gpr_rdata), $sampled(o_gpr_rdata));
  a_csr_rdata: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_csr_rdata == exp_csr_rdata)
    else report_mismatch("o_csr_rdata", $sampled(exp_csr_rdata), $sampled(o_csr_rdata));

  function automatic int csr_slot(input logic [`CSR_ADDR_WD-1:0] addr);
    case (addr)
      `CSR_MSTATUS: return 0;
      `CSR_MTVEC:   return 1;
      `CSR_MEPC:    return 2;
      `CSR_MCAUSE:  return 3;
      default:      return -1;
    endcase
  endfunction

  function automatic logic [`CSR_ADDR_WD-1:0] csr_addr_of(input int slot);
    case (slot)
      0:       return `CSR_MSTATUS;
      1:       return `CSR_MTVEC;
      2:       return `CSR_MEPC;
      default: return `CSR_MCAUSE;
    endcase
  endfunction

  // byte pick from the RAM word, then sign or zero fill
  function automatic logic [63:0] load_value(input logic [63:0] word, input int off,
                                             input int n, input logic uns);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = word[(off + i)*8 +: 8];
    end
    if (!uns && v[n*8-1]) begin
      v = v | ~((64'd1 << (n*8)) - 64'd1);
    end
    return v;
  endfunction

  function automatic ex_to_ms_t new_item();
    ex_to_ms_t it;
    it = '0;
    it.rd         = 5'($urandom);
    it.alu_result = {$urandom, $urandom};
    it.csr_addr   = 12'($urandom);
    it.csr_result = {$urandom, $urandom};
    it.store_data = {$urandom, $urandom};
    return it;
  endfunction

  function automatic ex_to_ms_t alu_item();
    ex_to_ms_t it;
    it = new_item();
    it.gpr_wen = 1'b1;
    return it;
  endfunction

  function automatic ex_to_ms_t csr_item(input logic [`CSR_ADDR_WD-1:0] addr);
    ex_to_ms_t it;
    it = new_item();
    it.csr_wen  = 1'b1;
    it.csr_addr = addr;
    it.gpr_wen  = 1'($urandom);
    return it;
  endfunction

  // naturally aligned access within the first RAM_WORDS words
  function automatic ex_to_ms_t mem_item(input mem_op_e op, input mem_size_e size);
    ex_to_ms_t  it;
    logic [2:0] off;
    it  = new_item();
    off = 3'(($urandom % (32'd8 >> size)) << size);
    it.alu_result    = 64'({$urandom % RAM_WORDS, off});
    it.mem_op        = op;
    it.mem_size      = size;
    it.load_unsigned = 1'($urandom);
    it.gpr_wen       = (op == MEM_LOAD);
    return it;
  endfunction

  // mirrors one clock edge of the pipeline, then picks the next read addresses
  task automatic advance_model(input logic take, input ex_to_ms_t item);
    logic                    wr_gpr;
    logic                    wr_csr;
    logic [`GPR_ADDR_WD-1:0] wr_rd;
    logic [`CSR_ADDR_WD-1:0] wr_caddr;
    logic [`DRAM_AW-1:0]     idx;
    int                      off;
    int                      n;
    int                      slot;
    logic [95:0]             head;
    wr_gpr   = m_ws_valid && m_ws.gpr_wen;
    wr_csr   = m_ws_valid && m_ws.csr_wen;
    wr_rd    = m_ws.rd;
    wr_caddr = m_ws.csr_addr;
    if (wr_gpr && wr_rd != '0) begin
      m_gpr[wr_rd] = m_ws.gpr_final_result;
    end
    slot = csr_slot(wr_caddr);
    if (wr_csr && slot >= 0) begin
      m_csr[slot] = m_ws.csr_final_result;
    end
    m_ws_valid = m_ms_valid;
    if (m_ms_valid) begin
      idx = m_ms.alu_result[`DRAM_AW+2:3];
      off = int'(m_ms.alu_result[2:0]);
      n   = 1 << int'(m_ms.mem_size);
      m_ws.pc               = m_ms.pc;
      m_ws.inst             = m_ms.inst;
      m_ws.gpr_wen          = m_ms.gpr_wen;
      m_ws.rd               = m_ms.rd;
      m_ws.gpr_final_result = m_ms.alu_result;
      m_ws.csr_wen          = m_ms.csr_wen;
      m_ws.csr_addr         = m_ms.csr_addr;
      m_ws.csr_final_result = m_ms.csr_result;
      if (m_ms.mem_op == MEM_LOAD) begin
        m_ws.gpr_final_result = load_value(m_ram[idx], off, n, m_ms.load_unsigned);
      end
      if (m_ms.mem_op == MEM_STORE) begin
        for (int i = 0; i < n; i++) begin
          m_ram[idx][(off + i)*8 +: 8] = m_ms.store_data[i*8 +: 8];
        end
      end
    end
    // each retirement from the DUT takes the oldest issued item
    if (o_retire_valid) begin
      if (retire_q.size() == 0) begin
        $display("retirement at t=%0t with no issued item left to match", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1);
      end else begin
        head        = retire_q.pop_front();
        exp_ws_pc   = head[95:32];
        exp_ws_inst = head[31:0];
      end
    end
    m_ms_valid = take;
    if (take) begin
      m_ms = item;
      retire_q.push_back({item.pc, item.inst});
    end
    // read back whatever was just written, otherwise somewhere random
    i_gpr_raddr   = wr_gpr ? wr_rd : 5'($urandom);
    exp_gpr_rdata = m_gpr[i_gpr_raddr];
    if (wr_csr) begin
      i_csr_raddr = wr_caddr;
    end else begin
      i_csr_raddr = ($urandom % 2 == 0) ? csr_addr_of($urandom % 4) : 12'($urandom);
    end
    slot = csr_slot(i_csr_raddr);
    exp_csr_rdata = (slot >= 0) ? m_csr[slot & 3] : '0;
  endtask

  task automatic tick();
    logic take;
    take = i_ex_to_ms_valid && o_ms_allowin;
    @(posedge i_clk);
    #2;
    advance_model(take, i_ex_to_ms_bus);
  endtask

  task automatic send(input ex_to_ms_t item);
    int waited;
    waited = 0;
    item.pc   = next_pc;
    item.inst = $urandom;
    next_pc   = next_pc + 64'd4;
    i_ex_to_ms_bus   = item;
    i_ex_to_ms_valid = 1'b1;
    while (!o_ms_allowin) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("o_ms_allowin");
      end
    end
    tick();
    i_ex_to_ms_valid = 1'b0;
    // idle gap, 0 to 2 cycles
    repeat ($urandom % 3) tick();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (m_ms_valid || m_ws_valid || o_retire_valid) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("the pipeline to drain");
      end
    end
    // one more edge so the last register write gets read back
    tick();
  endtask

  initial begin
    ex_to_ms_t it;
    ex_to_ms_t st;
    void'($urandom(47984));
    i_arst_n         = 1'b1;
    i_ex_to_ms_valid = 1'b0;
    i_ex_to_ms_bus   = '0;
    i_gpr_raddr      = '0;
    i_csr_raddr      = '0;
    for (int i = 0; i < 32; i++) begin
      m_gpr[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      m_csr[i] = '0;
    end
    m_ms_valid    = 1'b0;
    m_ws_valid    = 1'b0;
    m_ms          = '0;
    m_ws          = '0;
    exp_ws_pc     = '0;
    exp_ws_inst   = '0;
    exp_gpr_rdata = '0;
    exp_csr_rdata = '0;
    next_pc       = 64'h8000_0000;
    #1 i_arst_n = 1'b0;
    repeat (10) @(posedge i_clk);
    #2 i_arst_n = 1'b1;

    for (int i = 0; i < 20; i++) begin
      send(alu_item());
    end
    it = alu_item();
    it.rd = '0;
    send(it);

    // every word used by loads gets defined first
    for (int w = 0; w < RAM_WORDS; w++) begin
      it = mem_item(MEM_STORE, SIZE_D);
      it.alu_result = 64'(w) << 3;
      send(it);
    end
    for (int s = 0; s < 4; s++) begin
      for (int u = 0; u < 2; u++) begin
        st = mem_item(MEM_STORE, mem_size_e'(2'(s)));
        send(st);
        it = mem_item(MEM_LOAD, mem_size_e'(2'(s)));
        it.alu_result    = st.alu_result;
        it.load_unsigned = 1'(u);
        send(it);
      end
    end

    for (int i = 0; i < 4; i++) begin
      send(csr_item(csr_addr_of(i)));
    end
    send(csr_item(`CSR_MSTATUS ^ 12'h800));
    send(csr_item(`CSR_MEPC ^ 12'h800));

    for (int i = 0; i < 60; i++) begin
      case ($urandom % 4)
        0:       send(alu_item());
        1:       send(mem_item(MEM_STORE, mem_size_e'(2'($urandom))));
        2:       send(mem_item(MEM_LOAD, mem_size_e'(2'($urandom))));
        default: send(csr_item(csr_addr_of($urandom % 4)));
      endcase
    end

    drain();
    if (retire_q.size() != 0) begin
      $display("retire queue still holds %0d items at the end of the run", retire_q.size());
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/wb_top.sv
bench/tb_wb_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the back-end bench with Verilator and runs it; exit status is the test result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_wb_top \
  -f filelist.f \
  -o sim_wb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_wb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
